// ==== design/busPkg.sv ====
`default_nettype none

package busPkg;

	// ********************
	// field widths
	// ********************
	localparam int busAddressWidth = 24;
	localparam int localAddressWidth = 16;
	localparam int dataWidth = 32;
	localparam int byteLanes = dataWidth / 8;
	localparam int peripheralIdWidth = 8;	// top address bits naming a peripheral

	typedef logic [busAddressWidth-1:0] busAddress_t;
	typedef logic [localAddressWidth-1:0] localAddress_t;
	typedef logic [dataWidth-1:0] busData_t;
	typedef logic [byteLanes-1:0] byteSelect_t;

	// ********************
	// bus transfer
	// ********************

	// one cycle per transfer with we and oe never high together
	typedef struct packed {
		logic we;
		logic oe;
		busAddress_t address;
		byteSelect_t byteSelect;
		busData_t dataWrite;
	} busRequest_t;

	// registered read answer
	typedef struct packed {
		busData_t dataRead;
		logic requestOutput;	// read valid for one cycle
	} busResponse_t;

endpackage

`default_nettype wire

// ==== design/gpioPkg.sv ====
`default_nettype none

package gpioPkg;

	// ********************
	// pad bank
	// ********************
	localparam int padCount = 38;
	localparam int padCount1 = 19;	// low pads of device 1
	localparam int padCount2 = 19;	// high pads of device 2

	typedef logic [padCount-1:0] padVector_t;

	// ********************
	// local address map
	// ********************
	localparam int deviceFieldLsb = 12;	// device field is local bits 15:12

	typedef logic [3:0] deviceId_t;
	typedef logic [7:0] regOffset_t;

	localparam deviceId_t device1Id = 4'h1;
	localparam deviceId_t device2Id = 4'h2;

	// byte offsets inside a device
	localparam regOffset_t regOutput = 8'h00;
	localparam regOffset_t regOe = 8'h04;
	localparam regOffset_t regInput = 8'h08;	// read only
	localparam regOffset_t regSet = 8'h0C;	// write only
	localparam regOffset_t regClear = 8'h10;	// write only
	localparam regOffset_t regToggle = 8'h14;	// write only
	localparam regOffset_t regIdent = 8'h18;	// read only

	// ident word is {identPrefix, ioCount, 4'h0, deviceId}
	localparam logic [15:0] identPrefix = 16'h6710;

endpackage

`default_nettype wire

// ==== design/PeripheralSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

module PeripheralSelect import busPkg::*, gpioPkg::*; #(
	parameter logic [peripheralIdWidth-1:0] peripheralId = 8'h03
) (
	input logic clk,
	input logic arstN,
	input busAddress_t address,
	output localAddress_t localAddress,
	output logic [1:0] deviceEnable,
	input busResponse_t [1:0] deviceResponse,
	output busResponse_t response
);

	logic peripheralHit;
	deviceId_t deviceField;
	logic [1:0] selectQ;	// enables of the previous cycle

	assign peripheralHit = address[busAddressWidth-1 -: peripheralIdWidth] == peripheralId;
	assign localAddress = address[localAddressWidth-1:0];
	assign deviceField = localAddress[deviceFieldLsb +: 4];

	assign deviceEnable[0] = peripheralHit && (deviceField == device1Id);
	assign deviceEnable[1] = peripheralHit && (deviceField == device2Id);

	// a response is only taken from the device addressed one cycle before
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) selectQ <= '0;
		else selectQ <= deviceEnable;
	end

	// device 1 takes priority if both flags went bad
	always_comb begin
		if (selectQ[0] && deviceResponse[0].requestOutput) response = deviceResponse[0];
		else if (selectQ[1] && deviceResponse[1].requestOutput) response = deviceResponse[1];
		else response = '0;
	end

endmodule

`default_nettype wire

// ==== design/GPIODevice.sv ====
`timescale 1ns/1ps
`default_nettype none

module GPIODevice import busPkg::*, gpioPkg::*; #(
	parameter deviceId_t deviceId = device1Id,
	parameter int ioCount = 19	// 1 to 32
) (
	input logic clk,
	input logic arstN,
	input logic deviceEnable,
	input busRequest_t request,
	input localAddress_t localAddress,
	output busResponse_t response,
	input logic [ioCount-1:0] gpioInput,
	output logic [ioCount-1:0] gpioOutput,
	output logic [ioCount-1:0] gpioOe
);

	regOffset_t offset;
	logic writeHit;
	logic readHit;

	busData_t byteMask;
	logic [ioCount-1:0] writeMask;
	logic [ioCount-1:0] writeBits;	// dataWrite with lanes masked

	logic [ioCount-1:0] outputReg;
	logic [ioCount-1:0] oeReg;
	logic [ioCount-1:0] inputMeta;
	logic [ioCount-1:0] inputSync;

	busData_t identWord;
	busData_t readWord;

	assign offset = localAddress[7:0];
	assign writeHit = deviceEnable && request.we;
	assign readHit = deviceEnable && request.oe;

	// ********************
	// byte lanes
	// ********************
	always_comb begin
		for (int i = 0; i < byteLanes; i++) begin
			byteMask[i*8 +: 8] = {8{request.byteSelect[i]}};
		end
	end

	assign writeMask = byteMask[ioCount-1:0];
	assign writeBits = request.dataWrite[ioCount-1:0] & writeMask;

	// ********************
	// pad input
	// ********************

	// two flops as pads are asynchronous to clk
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			inputMeta <= '0;
			inputSync <= '0;
		end else begin
			inputMeta <= gpioInput;
			inputSync <= inputMeta;
		end
	end

	// ********************
	// register writes
	// ********************
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outputReg <= '0;
			oeReg <= '0;
		end else if (writeHit) begin
			case (offset)
				regOutput: outputReg <= (outputReg & ~writeMask) | writeBits;
				regOe: oeReg <= (oeReg & ~writeMask) | writeBits;
				regSet: outputReg <= outputReg | writeBits;
				regClear: outputReg <= outputReg & ~writeBits;
				regToggle: outputReg <= outputReg ^ writeBits;
				default: ;	// read only or unmapped
			endcase
		end
	end

	assign gpioOutput = outputReg;
	assign gpioOe = oeReg;

	// ********************
	// reads
	// ********************
	assign identWord = {identPrefix, 8'(ioCount), 4'h0, deviceId};

	always_comb begin
		case (offset)
			regOutput: readWord = busData_t'(outputReg);
			regOe: readWord = busData_t'(oeReg);
			regInput: readWord = busData_t'(inputSync);
			regIdent: readWord = identWord;
			default: readWord = '0;	// write only offsets read zero too
		endcase
	end

	// answer lands in the cycle after the read
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			response <= '0;
		end else begin
			response.requestOutput <= readHit;
			if (readHit) response.dataRead <= readWord;
		end
	end

endmodule

`default_nettype wire

// ==== design/GPIO.sv ====
`timescale 1ns/1ps
`default_nettype none

module GPIO import busPkg::*, gpioPkg::*; #(
	parameter logic [peripheralIdWidth-1:0] peripheralId = 8'h03
) (
	input logic clk,
	input logic arstN,
	input busRequest_t peripheralBus,
	output busResponse_t peripheralResponse,
	input padVector_t gpioInput,
	output padVector_t gpioOutput,
	output padVector_t gpioOe
);

	localAddress_t localAddress;
	logic [1:0] deviceEnable;
	busResponse_t [1:0] deviceResponse;

	logic [padCount1-1:0] gpio0Input;
	logic [padCount1-1:0] gpio0Output;
	logic [padCount1-1:0] gpio0Oe;
	logic [padCount2-1:0] gpio1Input;
	logic [padCount2-1:0] gpio1Output;
	logic [padCount2-1:0] gpio1Oe;

	// ********************
	// address decode
	// ********************
	PeripheralSelect #(.peripheralId(peripheralId)) select (
		.clk(clk),
		.arstN(arstN),
		.address(peripheralBus.address),
		.localAddress(localAddress),
		.deviceEnable(deviceEnable),
		.deviceResponse(deviceResponse),
		.response(peripheralResponse)
	);

	// ********************
	// devices
	// ********************
	GPIODevice #(.deviceId(device1Id), .ioCount(padCount1)) device0 (
		.clk(clk),
		.arstN(arstN),
		.deviceEnable(deviceEnable[0]),
		.request(peripheralBus),
		.localAddress(localAddress),
		.response(deviceResponse[0]),
		.gpioInput(gpio0Input),
		.gpioOutput(gpio0Output),
		.gpioOe(gpio0Oe)
	);

	GPIODevice #(.deviceId(device2Id), .ioCount(padCount2)) device1 (
		.clk(clk),
		.arstN(arstN),
		.deviceEnable(deviceEnable[1]),
		.request(peripheralBus),
		.localAddress(localAddress),
		.response(deviceResponse[1]),
		.gpioInput(gpio1Input),
		.gpioOutput(gpio1Output),
		.gpioOe(gpio1Oe)
	);

	// device 1 owns the low pads
	assign gpio0Input = gpioInput[padCount1-1:0];
	assign gpio1Input = gpioInput[padCount-1:padCount1];
	assign gpioOutput = {gpio1Output, gpio0Output};
	assign gpioOe = {gpio1Oe, gpio0Oe};

endmodule

`default_nettype wire

// ==== tests/GPIO_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module GPIO_props import busPkg::*; (
	input logic clk,
	input logic arstN,
	input busRequest_t peripheralBus,
	input logic [1:0] deviceEnable,
	input busResponse_t peripheralResponse
);

	logic readHit;

	assign readHit = peripheralBus.oe && (|deviceEnable);	// read to a mapped device

	// ********************
	// reset
	// ********************
	resetQuiet: assert property (
		@(posedge clk) !arstN |-> !peripheralResponse.requestOutput
	) else $error("read valid flag raised while in reset");

	// ********************
	// read timing
	// ********************
	readAnswered: assert property (
		@(posedge clk) disable iff (!arstN)
		readHit |=> peripheralResponse.requestOutput
	) else $error("read hit was not answered in the next cycle");

	// no answer without a read one cycle before
	noStrayResponse: assert property (
		@(posedge clk) disable iff (!arstN)
		!readHit |=> !peripheralResponse.requestOutput
	) else $error("read valid flag raised with no read in the cycle before");

endmodule

bind GPIO GPIO_props props (
	.clk(clk),
	.arstN(arstN),
	.peripheralBus(peripheralBus),
	.deviceEnable(deviceEnable),
	.peripheralResponse(peripheralResponse)
);

`default_nettype wire

// ==== tests/GPIO_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module GPIO_tb import busPkg::*, gpioPkg::*; ();

	localparam int clockPeriod = 8;
	localparam int watchdogCycles = 5000;	// several times the full run
	localparam logic [peripheralIdWidth-1:0] peripheralId = 8'h03;

	logic clk;
	logic arstN;
	busRequest_t peripheralBus;
	busResponse_t peripheralResponse;
	padVector_t gpioInput;
	padVector_t gpioOutput;
	padVector_t gpioOe;
	padVector_t externalDrive;	// what the board drives onto undriven pads

	logic [padCount1-1:0] expOut [2];
	logic [padCount1-1:0] expOe [2];
	integer seed;
	int checkCount;
	int errorCount;
	int testStartErrors;
	int testsFailed;

	// driven pads read back their own output
	assign gpioInput = (gpioOe & gpioOutput) | (~gpioOe & externalDrive);

	GPIO #(.peripheralId(peripheralId)) u_dut (
		.clk(clk),
		.arstN(arstN),
		.peripheralBus(peripheralBus),
		.peripheralResponse(peripheralResponse),
		.gpioInput(gpioInput),
		.gpioOutput(gpioOutput),
		.gpioOe(gpioOe)
	);

	initial begin
		clk = 1'b0;
		forever #(clockPeriod / 2) clk = ~clk;
	end

	initial begin
		#(watchdogCycles * clockPeriod);
		$display("timeout: the tests did not finish within %0d cycles", watchdogCycles);
		$display("RESULT: FAIL");
		$finish;
	end

	// ********************
	// model
	// ********************
	function automatic busAddress_t makeAddress(logic [7:0] pid, deviceId_t dev, regOffset_t off);
		return {pid, dev, 4'h0, off};
	endfunction

	function automatic deviceId_t deviceIdOf(int dev);
		return (dev == 0) ? device1Id : device2Id;
	endfunction

	function automatic logic [padCount1-1:0] laneBits(byteSelect_t lanes);
		busData_t mask;
		for (int i = 0; i < 4; i++) begin
			mask[i*8 +: 8] = {8{lanes[i]}};
		end
		return mask[padCount1-1:0];
	endfunction

	function automatic logic [padCount1-1:0] padSlice(padVector_t pads, int dev);
		return (dev == 0) ? pads[padCount1-1:0] : pads[padCount-1:padCount1];
	endfunction

	function automatic busData_t expectedRead(int dev, regOffset_t off);
		logic [padCount1-1:0] pads;
		pads = (expOe[dev] & expOut[dev]) | (~expOe[dev] & padSlice(externalDrive, dev));
		case (off)
			regOutput: return busData_t'(expOut[dev]);
			regOe: return busData_t'(expOe[dev]);
			regInput: return busData_t'(pads);
			regIdent: return {16'h6710, 8'((dev == 0) ? padCount1 : padCount2), 4'h0,
				deviceIdOf(dev)};
			default: return '0;
		endcase
	endfunction

	// ********************
	// checks and bus tasks
	// ********************
	task automatic checkValue(string name, busData_t got, busData_t expected);
		checkCount++;
		assert (got === expected) else begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
			errorCount++;
		end
	endtask

	task automatic checkTrue(bit condition, string what);
		checkCount++;
		assert (condition) else begin
			$display("%s", what);
			errorCount++;
		end
	endtask

	task automatic busWrite(busAddress_t address, byteSelect_t lanes, busData_t data);
		peripheralBus.we = 1'b1;
		peripheralBus.address = address;
		peripheralBus.byteSelect = lanes;
		peripheralBus.dataWrite = data;
		@(posedge clk);
		#1;
		peripheralBus.we = 1'b0;
	endtask

	task automatic busRead(busAddress_t address, output logic valid, output busData_t data);
		peripheralBus.oe = 1'b1;
		peripheralBus.address = address;
		@(posedge clk);
		#1;
		peripheralBus.oe = 1'b0;
		valid = peripheralResponse.requestOutput;	// answer of the cycle just ended
		data = peripheralResponse.dataRead;
	endtask

	task automatic writeReg(int dev, regOffset_t off, byteSelect_t lanes, busData_t data);
		logic [padCount1-1:0] mask;
		logic [padCount1-1:0] bits;
		mask = laneBits(lanes);
		bits = data[padCount1-1:0] & mask;
		case (off)
			regOutput: expOut[dev] = (expOut[dev] & ~mask) | bits;
			regOe: expOe[dev] = (expOe[dev] & ~mask) | bits;
			regSet: expOut[dev] = expOut[dev] | bits;
			regClear: expOut[dev] = expOut[dev] & ~bits;
			regToggle: expOut[dev] = expOut[dev] ^ bits;
			default: ;
		endcase
		busWrite(makeAddress(peripheralId, deviceIdOf(dev), off), lanes, data);
	endtask

	task automatic checkRead(int dev, regOffset_t off);
		logic valid;
		busData_t data;
		busRead(makeAddress(peripheralId, deviceIdOf(dev), off), valid, data);
		checkTrue(valid, $sformatf("device %0d gave no response at offset 0x%h", dev, off));
		checkValue($sformatf("dataRead dev%0d off 0x%h", dev, off), data, expectedRead(dev, off));
	endtask

	task automatic checkMiss(busAddress_t address);
		logic valid;
		busData_t data;
		busRead(address, valid, data);
		checkTrue(!valid, $sformatf("read at 0x%h got a response it should not", address));
	endtask

	task automatic checkPads();
		for (int dev = 0; dev < 2; dev++) begin
			checkValue($sformatf("gpioOutput dev%0d", dev),
				busData_t'(padSlice(gpioOutput, dev)), busData_t'(expOut[dev]));
			checkValue($sformatf("gpioOe dev%0d", dev),
				busData_t'(padSlice(gpioOe, dev)), busData_t'(expOe[dev]));
		end
	endtask

	task automatic finishTest(string name);
		if (errorCount == testStartErrors) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errorCount - testStartErrors);
			testsFailed++;
		end
		testStartErrors = errorCount;
	endtask

	// ********************
	// tests
	// ********************
	initial begin
		regOffset_t readOffsets [4];
		regOffset_t off;
		int dev;
		int pick;
		seed = 32'hea5c7bd5;
		readOffsets = '{regOutput, regOe, regInput, regIdent};
		arstN = 1'b0;
		peripheralBus = '0;
		externalDrive = '0;
		expOut = '{default: '0};
		expOe = '{default: '0};
		checkCount = 0;
		errorCount = 0;
		testStartErrors = 0;
		testsFailed = 0;
		repeat (4) @(posedge clk);
		#1;
		arstN = 1'b1;

		checkTrue(!peripheralResponse.requestOutput, "read valid flag is high after reset");
		checkValue("dataRead after reset", peripheralResponse.dataRead, '0);
		checkPads();
		for (int d = 0; d < 2; d++) begin
			checkRead(d, regOutput);
			checkRead(d, regOe);
		end
		finishTest("reset state");

		repeat (12) begin
			dev = $random(seed) & 1;
			off = ($random(seed) & 1) ? regOe : regOutput;
			writeReg(dev, off, byteSelect_t'($random(seed)), $random(seed));
			checkPads();
			checkRead(dev, off);
		end
		finishTest("byte-masked writes");

		repeat (24) begin
			dev = $random(seed) & 1;
			pick = $unsigned($random(seed)) % 3;
			off = (pick == 0) ? regSet : (pick == 1) ? regClear : regToggle;
			writeReg(dev, off, byteSelect_t'($random(seed)), $random(seed));
			checkPads();
		end
		checkRead(0, regOutput);
		checkRead(1, regOutput);
		finishTest("set clear toggle");

		repeat (8) begin
			externalDrive = padVector_t'({$random(seed), $random(seed)});
			repeat (2) @(posedge clk);	// synchronizer depth
			#1;
			checkRead(0, regInput);
			checkRead(1, regInput);
		end
		finishTest("input path");

		checkRead(0, regIdent);
		checkRead(1, regIdent);
		checkMiss(makeAddress(8'h04, device1Id, regIdent));
		checkMiss(makeAddress(peripheralId, 4'h3, regOutput));
		checkMiss(makeAddress(peripheralId, 4'h0, regOe));
		busWrite(makeAddress(8'h04, device1Id, regOutput), 4'hF, $random(seed));
		busWrite(makeAddress(peripheralId, 4'h3, regToggle), 4'hF, 32'hFFFF_FFFF);
		checkPads();
		checkRead(0, 8'h1C);
		checkRead(1, 8'h40);
		checkRead(1, regSet);
		finishTest("decode");

		// a new read goes out in the same cycle the previous one is answered
		for (int i = 0; i < 16; i++) begin
			dev = i % 2;
			off = readOffsets[$unsigned($random(seed)) % 4];
			peripheralBus.oe = 1'b1;
			peripheralBus.address = makeAddress(peripheralId, deviceIdOf(dev), off);
			@(posedge clk);
			#1;
			checkTrue(peripheralResponse.requestOutput,
				$sformatf("back-to-back read %0d was not answered", i));
			checkValue($sformatf("dataRead read %0d", i),
				peripheralResponse.dataRead, expectedRead(dev, off));
		end
		peripheralBus.oe = 1'b0;
		finishTest("back-to-back reads");

		$display("tests failed: %0d of 6, checks: %0d, errors: %0d",
			testsFailed, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
design/busPkg.sv
design/gpioPkg.sv
design/PeripheralSelect.sv
design/GPIODevice.sv
design/GPIO.sv
tests/GPIO_props.sv
tests/GPIO_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the GPIO testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simName=simGPIO
logFile=sim.log

verilator --binary --timing --assert \
	-f build.f \
	--top-module GPIO_tb \
	-Mdir "$buildDir" \
	-o "$simName"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator compile failed with status $status"
	exit 1
fi

"./$buildDir/$simName" > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^RESULT: PASS$" "$logFile"; then
	exit 0
fi
echo "pass message not found in $logFile"
exit 1
